/* src/mem_defines.svh */
// Widths, bank count, memory latency and address range macros for the banked AXI4-Lite memory
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// AXI4-Lite bus widths
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32
`define AXIL_STRB_W (`AXIL_DATA_W / 8)

// Byte address width of the whole memory, higher bits set means out of range
`define MEM_ADDR_W 12
// Byte offset inside one 32-bit word
`define MEM_BYTE_OFF_W 2

// Word interleaving over the banks, bank select sits right above the byte offset
`define MEM_NUM_BANKS 4
`define MEM_BANK_SEL_W 2
`define MEM_BANK_ADDR_W (`MEM_ADDR_W - `MEM_BYTE_OFF_W - `MEM_BANK_SEL_W)

// Cycles from granted request to bank rvalid
`define MEM_LATENCY 1

`endif

/* src/mem_pkg.sv */
// Package with converter states, response source tags and AXI response codes
package mem_pkg;

  // Converter FSM states, shared by read and write converters
  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT_MEM,
    RESPOND
  } path_state_e;

  // Which converter issued a bank request
  typedef enum logic {
    SRC_READ  = 1'b0,
    SRC_WRITE = 1'b1
  } mem_src_e;

  // AXI response codes in use, EXOKAY and DECERR never produced
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

endpackage

/* src/axil_read_path.sv */
// AR/R converter that issues one bank read per AXI4-Lite read and returns the data on R
`timescale 1ns/1ps
`include "mem_defines.svh"

module axil_read_path import mem_pkg::*; (
  input  logic                                            clk_i,
  input  logic                                            reset_i,
  input  logic                                            arvalid_i,
  input  logic [`AXIL_ADDR_W-1:0]                         araddr_i,
  output logic                                            arready_o,
  output logic                                            rvalid_o,
  input  logic                                            rready_i,
  output logic [`AXIL_DATA_W-1:0]                         rdata_o,
  output axil_resp_e                                      rresp_o,
  output logic [`MEM_NUM_BANKS-1:0]                       rd_req_o,
  input  logic [`MEM_NUM_BANKS-1:0]                       rd_gnt_i,
  output logic [`MEM_NUM_BANKS-1:0][`MEM_BANK_ADDR_W-1:0] rd_addr_o,
  input  logic [`MEM_NUM_BANKS-1:0]                       rd_rvalid_i,
  input  logic [`MEM_NUM_BANKS-1:0][`AXIL_DATA_W-1:0]     rd_rdata_i
);

  path_state_e                state_q, state_d;
  logic                       ar_hs;
  logic                       ar_oor;
  logic                       gnt_hit;
  logic                       rsp_hit;
  logic                       oor_q;
  logic [`MEM_BANK_SEL_W-1:0] bank_q;
  logic [`MEM_BANK_ADDR_W-1:0] word_q;
  logic [`AXIL_DATA_W-1:0]    rdata_q;
  logic [`MEM_NUM_BANKS-1:0]  bank_oh;

  // Only one read in flight, AR taken in IDLE only
  assign arready_o = (state_q == IDLE);
  assign ar_hs     = arvalid_i & arready_o;
  // Any address bit above the memory range
  assign ar_oor    = |araddr_i[`AXIL_ADDR_W-1:`MEM_ADDR_W];

  // One-hot bank, request and address on the selected slice only
  always_comb begin
    for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
      bank_oh[b]   = (int'(bank_q) == b);
      rd_req_o[b]  = (state_q == ISSUE) & bank_oh[b];
      rd_addr_o[b] = bank_oh[b] ? word_q : '0;
    end
  end

  assign gnt_hit = |(rd_gnt_i & bank_oh);
  assign rsp_hit = |(rd_rvalid_i & bank_oh);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      // out-of-range reads skip the bank entirely
      IDLE:     if (ar_hs) state_d = ar_oor ? RESPOND : ISSUE;
      ISSUE:    if (gnt_hit) state_d = WAIT_MEM;
      WAIT_MEM: if (rsp_hit) state_d = RESPOND;
      RESPOND:  if (rready_i) state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request payload and read data
  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      oor_q  <= ar_oor;
      bank_q <= araddr_i[`MEM_BYTE_OFF_W +: `MEM_BANK_SEL_W];
      word_q <= araddr_i[`MEM_ADDR_W-1:`MEM_BYTE_OFF_W+`MEM_BANK_SEL_W];
      // Error reads return zero data
      if (ar_oor) begin
        rdata_q <= '0;
      end
    end
    if ((state_q == WAIT_MEM) && rsp_hit) begin
      rdata_q <= rd_rdata_i[bank_q];
    end
  end

  // R held stable in RESPOND until rready_i
  assign rvalid_o = (state_q == RESPOND);
  assign rdata_o  = rdata_q;
  assign rresp_o  = oor_q ? SLVERR : OKAY;

endmodule

/* src/axil_write_path.sv */
// AW/W/B converter that joins address and data, issues one bank write and answers on B
`timescale 1ns/1ps
`include "mem_defines.svh"

module axil_write_path import mem_pkg::*; (
  input  logic                                            clk_i,
  input  logic                                            reset_i,
  input  logic                                            awvalid_i,
  input  logic [`AXIL_ADDR_W-1:0]                         awaddr_i,
  output logic                                            awready_o,
  input  logic                                            wvalid_i,
  input  logic [`AXIL_DATA_W-1:0]                         wdata_i,
  input  logic [`AXIL_STRB_W-1:0]                         wstrb_i,
  output logic                                            wready_o,
  output logic                                            bvalid_o,
  input  logic                                            bready_i,
  output axil_resp_e                                      bresp_o,
  output logic [`MEM_NUM_BANKS-1:0]                       wr_req_o,
  input  logic [`MEM_NUM_BANKS-1:0]                       wr_gnt_i,
  output logic [`MEM_NUM_BANKS-1:0][`MEM_BANK_ADDR_W-1:0] wr_addr_o,
  output logic [`MEM_NUM_BANKS-1:0][`AXIL_DATA_W-1:0]     wr_wdata_o,
  output logic [`MEM_NUM_BANKS-1:0][`AXIL_STRB_W-1:0]     wr_strb_o,
  input  logic [`MEM_NUM_BANKS-1:0]                       wr_rvalid_i
);

  path_state_e                 state_q, state_d;
  logic                        aw_hs, w_hs, b_hs;
  logic                        aw_oor_in;
  logic                        aw_oor_c;
  logic                        aw_have, w_have;
  logic                        gnt_hit, rsp_hit;
  logic                        aw_valid_q, w_valid_q;
  logic                        aw_oor_q;
  logic [`MEM_BANK_SEL_W-1:0]  bank_q;
  logic [`MEM_BANK_ADDR_W-1:0] word_q;
  logic [`AXIL_DATA_W-1:0]     wdata_q;
  logic [`AXIL_STRB_W-1:0]     wstrb_q;
  logic [`MEM_NUM_BANKS-1:0]   bank_oh;

  // Each channel ready in IDLE until its own beat is held
  assign awready_o = (state_q == IDLE) & ~aw_valid_q;
  assign wready_o  = (state_q == IDLE) & ~w_valid_q;
  assign aw_hs     = awvalid_i & awready_o;
  assign w_hs      = wvalid_i & wready_o;
  assign b_hs      = bvalid_o & bready_i;

  assign aw_oor_in = |awaddr_i[`AXIL_ADDR_W-1:`MEM_ADDR_W];

  // Both halves present, counting a beat taken on this edge
  assign aw_have  = aw_valid_q | aw_hs;
  assign w_have   = w_valid_q | w_hs;
  assign aw_oor_c = aw_valid_q ? aw_oor_q : aw_oor_in;

  always_comb begin
    for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
      bank_oh[b]    = (int'(bank_q) == b);
      wr_req_o[b]   = (state_q == ISSUE) & bank_oh[b];
      wr_addr_o[b]  = bank_oh[b] ? word_q : '0;
      wr_wdata_o[b] = bank_oh[b] ? wdata_q : '0;
      wr_strb_o[b]  = bank_oh[b] ? wstrb_q : '0;
    end
  end

  assign gnt_hit = |(wr_gnt_i & bank_oh);
  // Bank answers a write with rvalid as well
  assign rsp_hit = |(wr_rvalid_i & bank_oh);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (aw_have && w_have) begin
          state_d = aw_oor_c ? RESPOND : ISSUE;
        end
      end
      ISSUE:    if (gnt_hit) state_d = WAIT_MEM;
      WAIT_MEM: if (rsp_hit) state_d = RESPOND;
      RESPOND:  if (bready_i) state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  // FSM and holding flags
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= IDLE;
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // Flags released once B is taken
      if (b_hs) begin
        aw_valid_q <= 1'b0;
        w_valid_q  <= 1'b0;
      end else begin
        if (aw_hs) aw_valid_q <= 1'b1;
        if (w_hs) w_valid_q <= 1'b1;
      end
    end
  end

  // AW and W holding registers
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      aw_oor_q <= aw_oor_in;
      bank_q   <= awaddr_i[`MEM_BYTE_OFF_W +: `MEM_BANK_SEL_W];
      word_q   <= awaddr_i[`MEM_ADDR_W-1:`MEM_BYTE_OFF_W+`MEM_BANK_SEL_W];
    end
    if (w_hs) begin
      wdata_q <= wdata_i;
      wstrb_q <= wstrb_i;
    end
  end

  assign bvalid_o = (state_q == RESPOND);
  assign bresp_o  = aw_oor_q ? SLVERR : OKAY;

endmodule

/* src/bank_arbiter.sv */
// Per-bank round-robin arbiter for read and write requests with a response route queue
`timescale 1ns/1ps
`include "mem_defines.svh"

module bank_arbiter import mem_pkg::*; (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        rd_req_i,
  input  logic [`MEM_BANK_ADDR_W-1:0] rd_addr_i,
  output logic                        rd_gnt_o,
  input  logic                        wr_req_i,
  input  logic [`MEM_BANK_ADDR_W-1:0] wr_addr_i,
  input  logic [`AXIL_DATA_W-1:0]     wr_wdata_i,
  input  logic [`AXIL_STRB_W-1:0]     wr_strb_i,
  output logic                        wr_gnt_o,
  output logic                        mem_req_o,
  input  logic                        mem_gnt_i,
  output logic [`MEM_BANK_ADDR_W-1:0] mem_addr_o,
  output logic [`AXIL_DATA_W-1:0]     mem_wdata_o,
  output logic [`AXIL_STRB_W-1:0]     mem_strb_o,
  output logic                        mem_we_o,
  input  logic                        mem_rvalid_i,
  output mem_src_e                    rsp_src_o
);

  // One slot per cycle of latency plus the slot being pushed
  localparam int QDEPTH = `MEM_LATENCY + 1;
  localparam int PTR_W  = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;

  logic             prio_wr_q;
  logic             sel_wr;
  logic             push, pop;
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  mem_src_e         route_q [QDEPTH];

  // Write wins when alone or when it lost the last contested round
  assign sel_wr = wr_req_i & (~rd_req_i | prio_wr_q);

  assign mem_req_o   = rd_req_i | wr_req_i;
  assign mem_we_o    = sel_wr;
  assign mem_addr_o  = sel_wr ? wr_addr_i : rd_addr_i;
  assign mem_wdata_o = sel_wr ? wr_wdata_i : '0;
  assign mem_strb_o  = sel_wr ? wr_strb_i : '0;

  // Bank grant goes back to the winner only
  assign wr_gnt_o = sel_wr & mem_gnt_i;
  assign rd_gnt_o = ~sel_wr & rd_req_i & mem_gnt_i;

  assign push = mem_req_o & mem_gnt_i;
  assign pop  = mem_rvalid_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prio_wr_q <= 1'b0;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
    end else begin
      // Pointer moves only on an accepted contested request
      if (push && rd_req_i && wr_req_i) begin
        prio_wr_q <= ~sel_wr;
      end
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(QDEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(QDEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  // Route queue storage, tags each accepted request with its source
  always_ff @(posedge clk_i) begin
    if (push) begin
      route_q[wr_ptr_q] <= sel_wr ? SRC_WRITE : SRC_READ;
    end
  end

  // Head of queue owns the response arriving now
  assign rsp_src_o = route_q[rd_ptr_q];

endmodule

/* src/axil_to_mem_interleaved.sv */
// Top level joining read and write converters to per-bank arbiters and forming busy_o
`timescale 1ns/1ps
`include "mem_defines.svh"

module axil_to_mem_interleaved import mem_pkg::*; (
  input  logic                                            clk_i,
  input  logic                                            reset_i,
  output logic                                            busy_o,
  input  logic                                            awvalid_i,
  output logic                                            awready_o,
  input  logic [`AXIL_ADDR_W-1:0]                         awaddr_i,
  input  logic                                            wvalid_i,
  output logic                                            wready_o,
  input  logic [`AXIL_DATA_W-1:0]                         wdata_i,
  input  logic [`AXIL_STRB_W-1:0]                         wstrb_i,
  output logic                                            bvalid_o,
  input  logic                                            bready_i,
  output axil_resp_e                                      bresp_o,
  input  logic                                            arvalid_i,
  output logic                                            arready_o,
  input  logic [`AXIL_ADDR_W-1:0]                         araddr_i,
  output logic                                            rvalid_o,
  input  logic                                            rready_i,
  output logic [`AXIL_DATA_W-1:0]                         rdata_o,
  output axil_resp_e                                      rresp_o,
  output logic [`MEM_NUM_BANKS-1:0]                       mem_req_o,
  input  logic [`MEM_NUM_BANKS-1:0]                       mem_gnt_i,
  output logic [`MEM_NUM_BANKS-1:0][`MEM_BANK_ADDR_W-1:0] mem_addr_o,
  output logic [`MEM_NUM_BANKS-1:0][`AXIL_DATA_W-1:0]     mem_wdata_o,
  output logic [`MEM_NUM_BANKS-1:0][`AXIL_STRB_W-1:0]     mem_strb_o,
  output logic [`MEM_NUM_BANKS-1:0]                       mem_we_o,
  input  logic [`MEM_NUM_BANKS-1:0]                       mem_rvalid_i,
  input  logic [`MEM_NUM_BANKS-1:0][`AXIL_DATA_W-1:0]     mem_rdata_i
);

  // Internal bank buses, one slice per bank
  logic [`MEM_NUM_BANKS-1:0]                       rd_req, rd_gnt, rd_rvalid;
  logic [`MEM_NUM_BANKS-1:0][`MEM_BANK_ADDR_W-1:0] rd_addr;
  logic [`MEM_NUM_BANKS-1:0]                       wr_req, wr_gnt, wr_rvalid;
  logic [`MEM_NUM_BANKS-1:0][`MEM_BANK_ADDR_W-1:0] wr_addr;
  logic [`MEM_NUM_BANKS-1:0][`AXIL_DATA_W-1:0]     wr_wdata;
  logic [`MEM_NUM_BANKS-1:0][`AXIL_STRB_W-1:0]     wr_strb;
  mem_src_e                                        rsp_src [`MEM_NUM_BANKS];

  // Ready outputs drop exactly when a converter leaves IDLE or holds a beat
  assign busy_o = ~arready_o | ~awready_o | ~wready_o;

  axil_read_path i_read_path (
    .clk_i, .reset_i, .arvalid_i, .araddr_i, .arready_o,
    .rvalid_o, .rready_i, .rdata_o, .rresp_o,
    .rd_req_o    ( rd_req      ),
    .rd_gnt_i    ( rd_gnt      ),
    .rd_addr_o   ( rd_addr     ),
    .rd_rvalid_i ( rd_rvalid   ),
    .rd_rdata_i  ( mem_rdata_i )
  );

  axil_write_path i_write_path (
    .clk_i, .reset_i, .awvalid_i, .awaddr_i, .awready_o,
    .wvalid_i, .wdata_i, .wstrb_i, .wready_o, .bvalid_o, .bready_i, .bresp_o,
    .wr_req_o    ( wr_req    ),
    .wr_gnt_i    ( wr_gnt    ),
    .wr_addr_o   ( wr_addr   ),
    .wr_wdata_o  ( wr_wdata  ),
    .wr_strb_o   ( wr_strb   ),
    .wr_rvalid_i ( wr_rvalid )
  );

  for (genvar b = 0; b < `MEM_NUM_BANKS; b++) begin : g_bank
    bank_arbiter i_bank_arbiter (
      .clk_i, .reset_i,
      .rd_req_i  ( rd_req[b]  ), .rd_addr_i ( rd_addr[b] ), .rd_gnt_o ( rd_gnt[b] ),
      .wr_req_i  ( wr_req[b]  ), .wr_addr_i ( wr_addr[b] ), .wr_wdata_i ( wr_wdata[b] ),
      .wr_strb_i ( wr_strb[b] ), .wr_gnt_o  ( wr_gnt[b]  ),
      .mem_req_o ( mem_req_o[b] ), .mem_gnt_i ( mem_gnt_i[b] ), .mem_addr_o ( mem_addr_o[b] ),
      .mem_wdata_o  ( mem_wdata_o[b]  ), .mem_strb_o ( mem_strb_o[b] ),
      .mem_we_o     ( mem_we_o[b]     ),
      .mem_rvalid_i ( mem_rvalid_i[b] ), .rsp_src_o  ( rsp_src[b]    )
    );

    // Response goes to the converter that issued the request
    assign rd_rvalid[b] = mem_rvalid_i[b] & (rsp_src[b] == SRC_READ);
    assign wr_rvalid[b] = mem_rvalid_i[b] & (rsp_src[b] == SRC_WRITE);
  end

endmodule

/* testbench/tb_clock_gen.sv */
// Testbench clock generator with a 4 ns period and a reset held for two cycles
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset released on a falling edge, seen high on exactly RESET_CYCLES rising edges
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

/* testbench/tb_mem_banks.sv */
// Behavioral SRAM banks with random grant stalls and a fixed response latency
`timescale 1ns/1ps
`include "mem_defines.svh"

module tb_mem_banks (
  input  logic                                            clk_i,
  input  logic                                            reset_i,
  input  logic [`MEM_NUM_BANKS-1:0]                       mem_req_i,
  output logic [`MEM_NUM_BANKS-1:0]                       mem_gnt_o,
  input  logic [`MEM_NUM_BANKS-1:0][`MEM_BANK_ADDR_W-1:0] mem_addr_i,
  input  logic [`MEM_NUM_BANKS-1:0][`AXIL_DATA_W-1:0]     mem_wdata_i,
  input  logic [`MEM_NUM_BANKS-1:0][`AXIL_STRB_W-1:0]     mem_strb_i,
  input  logic [`MEM_NUM_BANKS-1:0]                       mem_we_i,
  output logic [`MEM_NUM_BANKS-1:0]                       mem_rvalid_o,
  output logic [`MEM_NUM_BANKS-1:0][`AXIL_DATA_W-1:0]     mem_rdata_o
);

  localparam int WORDS = 2 ** `MEM_BANK_ADDR_W;

  logic [`AXIL_DATA_W-1:0]                     mem [`MEM_NUM_BANKS][WORDS];
  logic [`MEM_NUM_BANKS-1:0]                   vld_pipe [`MEM_LATENCY];
  logic [`MEM_NUM_BANKS-1:0][`AXIL_DATA_W-1:0] dat_pipe [`MEM_LATENCY];

  // Fill pattern over the full word index {row, bank}
  initial begin
    for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
      for (int w = 0; w < WORDS; w++) begin
        mem[b][w] = (32'(w * `MEM_NUM_BANKS + b) * 32'h0100_0193) ^ 32'h5a5a_a5a5;
      end
    end
  end

  // Bank outputs start idle before the first clock edge
  initial begin
    mem_gnt_o = '0;
    for (int s = 0; s < `MEM_LATENCY; s++) begin
      vld_pipe[s] = '0;
      dat_pipe[s] = '0;
    end
  end

  // Roughly one cycle in four stalls each bank
  always @(posedge clk_i) begin
    for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
      mem_gnt_o[b] <= reset_i ? 1'b0 : (($urandom % 4) != 0);
    end
  end

  // Accepted request, reads return old data, writes merge per byte
  always @(posedge clk_i) begin
    for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
      vld_pipe[0][b] <= ~reset_i & mem_req_i[b] & mem_gnt_o[b];
      if (mem_req_i[b] && mem_gnt_o[b]) begin
        dat_pipe[0][b] <= mem[b][mem_addr_i[b]];
        for (int k = 0; k < `AXIL_STRB_W; k++) begin
          if (mem_we_i[b] && mem_strb_i[b][k]) begin
            mem[b][mem_addr_i[b]][8*k +: 8] <= mem_wdata_i[b][8*k +: 8];
          end
        end
      end
    end
    // Longer latencies shift through extra stages
    for (int s = 1; s < `MEM_LATENCY; s++) begin
      vld_pipe[s] <= reset_i ? '0 : vld_pipe[s-1];
      dat_pipe[s] <= dat_pipe[s-1];
    end
  end

  assign mem_rvalid_o = vld_pipe[`MEM_LATENCY-1];
  assign mem_rdata_o  = dat_pipe[`MEM_LATENCY-1];

endmodule

/* testbench/tb_axil_to_mem.sv */
// Testbench top with AXI4-Lite stimulus, reference memory, concurrent assertions and watchdog
`timescale 1ns/1ps
`include "mem_defines.svh"

module tb_axil_to_mem import mem_pkg::*; ();

  localparam int CLK_PERIOD_NS = 4;
  localparam int RESET_CYCLES  = 2;
  localparam int ITER          = 8;
  // Three paired tests, then two rounds of two out-of-range transactions and one alias read
  localparam int NUM_TXN       = 6 * ITER + 3 * 2;
  localparam int TXN_BOUND     = 64;
  localparam int TIMEOUT_NS    = (RESET_CYCLES + NUM_TXN * TXN_BOUND) * CLK_PERIOD_NS;

  typedef logic [`MEM_BANK_SEL_W-1:0]  bank_t;
  typedef logic [`MEM_BANK_ADDR_W-1:0] row_t;

  logic clk, reset, busy;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [`AXIL_ADDR_W-1:0] awaddr, araddr;
  logic [`AXIL_DATA_W-1:0] wdata, rdata;
  logic [`AXIL_STRB_W-1:0] wstrb;
  axil_resp_e              bresp, rresp;

  logic [`MEM_NUM_BANKS-1:0]                       mem_req, mem_gnt, mem_we, mem_rvalid;
  logic [`MEM_NUM_BANKS-1:0][`MEM_BANK_ADDR_W-1:0] mem_addr;
  logic [`MEM_NUM_BANKS-1:0][`AXIL_DATA_W-1:0]     mem_wdata, mem_rdata;
  logic [`MEM_NUM_BANKS-1:0][`AXIL_STRB_W-1:0]     mem_strb;

  // Reference memory, only words written so far are stored
  logic [`AXIL_DATA_W-1:0] ref_mem [int];
  logic [`AXIL_DATA_W-1:0] exp_rdata;
  axil_resp_e              exp_rresp, exp_bresp;
  logic                    oor_window;
  logic                    rd_open, wr_open;
  // Previous-edge copies for the hold and reset checks
  logic                    reset_q, r_stall_q, b_stall_q;
  logic [`AXIL_DATA_W-1:0] rdata_q;
  axil_resp_e              bresp_q;
  int assert_errors;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) clock_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  axil_to_mem_interleaved dut (
    .clk_i        (clk),
    .reset_i      (reset),
    .busy_o       (busy),
    .awvalid_i    (awvalid),
    .awready_o    (awready),
    .awaddr_i     (awaddr),
    .wvalid_i     (wvalid),
    .wready_o     (wready),
    .wdata_i      (wdata),
    .wstrb_i      (wstrb),
    .bvalid_o     (bvalid),
    .bready_i     (bready),
    .bresp_o      (bresp),
    .arvalid_i    (arvalid),
    .arready_o    (arready),
    .araddr_i     (araddr),
    .rvalid_o     (rvalid),
    .rready_i     (rready),
    .rdata_o      (rdata),
    .rresp_o      (rresp),
    .mem_req_o    (mem_req),
    .mem_gnt_i    (mem_gnt),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_strb_o   (mem_strb),
    .mem_we_o     (mem_we),
    .mem_rvalid_i (mem_rvalid),
    .mem_rdata_i  (mem_rdata)
  );

  tb_mem_banks banks (
    .clk_i        (clk),
    .reset_i      (reset),
    .mem_req_i    (mem_req),
    .mem_gnt_o    (mem_gnt),
    .mem_addr_i   (mem_addr),
    .mem_wdata_i  (mem_wdata),
    .mem_strb_i   (mem_strb),
    .mem_we_i     (mem_we),
    .mem_rvalid_o (mem_rvalid),
    .mem_rdata_o  (mem_rdata)
  );

  // Initial bank contents, indexed by word address
  function automatic logic [31:0] fill_word(input int w);
    return (32'(w) * 32'h0100_0193) ^ 32'h5a5a_a5a5;
  endfunction

  function automatic logic [31:0] ref_read(input int w);
    if (ref_mem.exists(w)) begin
      return ref_mem[w];
    end
    return fill_word(w);
  endfunction

  function automatic logic [31:0] merge_strb(input logic [31:0] old, input logic [31:0] data,
                                             input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int k = 0; k < `AXIL_STRB_W; k++) begin
      if (strb[k]) res[8*k +: 8] = data[8*k +: 8];
    end
    return res;
  endfunction

  // Word index aliases out-of-range addresses onto the memory
  function automatic int word_of(input logic [31:0] addr);
    return int'(addr[`MEM_ADDR_W-1:`MEM_BYTE_OFF_W]);
  endfunction

  function automatic logic [31:0] word_addr(input bank_t bank, input row_t row);
    return {{(`AXIL_ADDR_W - `MEM_ADDR_W){1'b0}}, row, bank, 2'b00};
  endfunction

  task automatic report_error(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    assert_errors++;
    $display("error at %0d ns: %s got %h expected %h", $time, name, got, exp);
  endtask

  // Open transactions and previous-edge values
  always_ff @(posedge clk) begin
    reset_q   <= reset;
    r_stall_q <= rvalid && !rready;
    b_stall_q <= bvalid && !bready;
    rdata_q   <= rdata;
    bresp_q   <= bresp;
    if (reset) begin
      rd_open <= 1'b0;
      wr_open <= 1'b0;
    end else begin
      if (arvalid && arready) rd_open <= 1'b1;
      else if (rvalid && rready) rd_open <= 1'b0;
      if ((awvalid && awready) || (wvalid && wready)) wr_open <= 1'b1;
      else if (bvalid && bready) wr_open <= 1'b0;
    end
  end

  // First cycle after reset release
  a_rst_rvalid: assert property (@(posedge clk) reset_q && !reset |-> !rvalid)
    else report_error("rvalid_o", 32'(rvalid), 32'd0);
  a_rst_bvalid: assert property (@(posedge clk) reset_q && !reset |-> !bvalid)
    else report_error("bvalid_o", 32'(bvalid), 32'd0);
  a_rst_req: assert property (@(posedge clk) reset_q && !reset |-> mem_req == '0)
    else report_error("mem_req_o", 32'(mem_req), 32'd0);
  a_rst_busy: assert property (@(posedge clk) reset_q && !reset |-> !busy)
    else report_error("busy_o", 32'(busy), 32'd0);
  a_rst_arready: assert property (@(posedge clk) reset_q && !reset |-> arready)
    else report_error("arready_o", 32'(arready), 32'd1);
  a_rst_awready: assert property (@(posedge clk) reset_q && !reset |-> awready)
    else report_error("awready_o", 32'(awready), 32'd1);
  a_rst_wready: assert property (@(posedge clk) reset_q && !reset |-> wready)
    else report_error("wready_o", 32'(wready), 32'd1);

  // Response contents on handshake
  a_rdata: assert property (@(posedge clk) disable iff (reset)
    rvalid && rready |-> rdata == exp_rdata)
    else report_error("rdata_o", rdata, exp_rdata);
  a_rresp: assert property (@(posedge clk) disable iff (reset)
    rvalid && rready |-> rresp == exp_rresp)
    else report_error("rresp_o", 32'(rresp), 32'(exp_rresp));
  a_bresp: assert property (@(posedge clk) disable iff (reset)
    bvalid && bready |-> bresp == exp_bresp)
    else report_error("bresp_o", 32'(bresp), 32'(exp_bresp));

  // Out-of-range traffic never reaches a bank
  a_oor_req: assert property (@(posedge clk) disable iff (reset)
    oor_window |-> mem_req == '0)
    else report_error("mem_req_o", 32'(mem_req), 32'd0);

  // Stalled responses hold
  a_rvalid_hold: assert property (@(posedge clk) disable iff (reset) r_stall_q |-> rvalid)
    else report_error("rvalid_o", 32'(rvalid), 32'd1);
  a_rdata_hold: assert property (@(posedge clk) disable iff (reset)
    r_stall_q |-> rdata == rdata_q)
    else report_error("rdata_o", rdata, rdata_q);
  a_bvalid_hold: assert property (@(posedge clk) disable iff (reset) b_stall_q |-> bvalid)
    else report_error("bvalid_o", 32'(bvalid), 32'd1);
  a_bresp_hold: assert property (@(posedge clk) disable iff (reset)
    b_stall_q |-> bresp == bresp_q)
    else report_error("bresp_o", 32'(bresp), 32'(bresp_q));

  a_busy: assert property (@(posedge clk) disable iff (reset) rd_open || wr_open |-> busy)
    else report_error("busy_o", 32'(busy), 32'd1);

  // One read with random R back-pressure
  task automatic read_txn(input logic [31:0] addr);
    logic oor;
    oor = |addr[`AXIL_ADDR_W-1:`MEM_ADDR_W];
    exp_rdata = oor ? '0 : ref_read(word_of(addr));
    exp_rresp = oor ? SLVERR : OKAY;
    @(negedge clk);
    arvalid = 1'b1;
    araddr = addr;
    while (!arready) @(negedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    forever begin
      rready = ($urandom % 4) == 0;
      if (rvalid && rready) break;
      @(negedge clk);
    end
    @(negedge clk);
    rready = 1'b0;
  endtask

  // One write, AW and W skewed at random, then B with back-pressure
  task automatic write_txn(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    int aw_dly;
    int w_dly;
    aw_dly = $urandom % 3;
    w_dly = $urandom % 3;
    if (|addr[`AXIL_ADDR_W-1:`MEM_ADDR_W]) begin
      exp_bresp = SLVERR;
    end else begin
      exp_bresp = OKAY;
      ref_mem[word_of(addr)] = merge_strb(ref_read(word_of(addr)), data, strb);
    end
    fork
      begin
        repeat (aw_dly) @(negedge clk);
        @(negedge clk);
        awvalid = 1'b1;
        awaddr = addr;
        while (!awready) @(negedge clk);
        @(negedge clk);
        awvalid = 1'b0;
      end
      begin
        repeat (w_dly) @(negedge clk);
        @(negedge clk);
        wvalid = 1'b1;
        wdata = data;
        wstrb = strb;
        while (!wready) @(negedge clk);
        @(negedge clk);
        wvalid = 1'b0;
      end
    join
    forever begin
      bready = ($urandom % 4) == 0;
      if (bvalid && bready) break;
      @(negedge clk);
    end
    @(negedge clk);
    bready = 1'b0;
  endtask

  initial begin
    logic [31:0] addr_a;
    logic [31:0] addr_b;
    bank_t       bank;
    row_t        row;
    void'($urandom(32'h6f457abf));
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    bready = 1'b0;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b0;
    oor_window = 1'b0;
    exp_rdata = '0;
    exp_rresp = OKAY;
    exp_bresp = OKAY;
    assert_errors = 0;
    wait (!reset);
    @(negedge clk);

    // Write then read back the same word
    repeat (ITER) begin
      addr_a = word_addr(bank_t'($urandom), row_t'($urandom));
      write_txn(addr_a, $urandom, 4'($urandom));
      read_txn(addr_a);
    end

    // Read and write side by side on different banks
    repeat (ITER) begin
      bank = bank_t'($urandom);
      addr_a = word_addr(bank, row_t'($urandom));
      addr_b = word_addr(bank ^ (bank_t'($urandom) | bank_t'(1)), row_t'($urandom));
      fork
        read_txn(addr_a);
        write_txn(addr_b, $urandom, 4'($urandom));
      join
    end

    // Same bank, different words, arbiter and route queue under stalls
    repeat (ITER) begin
      bank = bank_t'($urandom);
      row = row_t'($urandom);
      addr_a = word_addr(bank, row);
      addr_b = word_addr(bank, row ^ (row_t'($urandom) | row_t'(1)));
      fork
        read_txn(addr_a);
        write_txn(addr_b, $urandom, 4'($urandom));
      join
    end

    // Out-of-range write and read, then the aliased word must be unchanged
    repeat (2) begin
      addr_a = word_addr(bank_t'($urandom), row_t'($urandom));
      addr_b = addr_a | ((32'($urandom) | 32'h1) << `MEM_ADDR_W);
      oor_window = 1'b1;
      write_txn(addr_b, $urandom, 4'hf);
      read_txn(addr_b);
      oor_window = 1'b0;
      read_txn(addr_a);
    end

    repeat (4) @(negedge clk);
    $display("summary: %0d assertion errors", assert_errors);
    if (assert_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog sized from the transaction count
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* tb.f */
+incdir+src
src/mem_pkg.sv
src/axil_read_path.sv
src/axil_write_path.sv
src/bank_arbiter.sv
src/axil_to_mem_interleaved.sv
testbench/tb_clock_gen.sv
testbench/tb_mem_banks.sv
testbench/tb_axil_to_mem.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the testbench with Verilator, pass only if the log holds the pass line
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_axil_to_mem -f tb.f
./obj_dir/Vtb_axil_to_mem 2>&1 | tee sim.log
grep -qF '*** TEST PASSED ***' sim.log
